//--- logic/videoPkg.sv
//----------------------------------------------------------
// Shared widths and types of the video transmit path
// Imported by every block that carries positions or pixels
//----------------------------------------------------------
package videoPkg;

	// Counter widths for the raster timing
	localparam int cHPosWidth  = 11;
	localparam int cVPosWidth  = 11;

	// One color channel at the TFT pins
	localparam int cColorWidth = 4;
	localparam int cRgbWidth   = 3 * cColorWidth;

	// Backlight duty resolution
	localparam int cDutyWidth  = 8;

	// Horizontal and vertical position or timing value
	typedef logic [cHPosWidth-1:0] hPos_t;
	typedef logic [cVPosWidth-1:0] vPos_t;

	// Pixel as R[11:8] G[7:4] B[3:0], alpha already stripped
	typedef logic [cRgbWidth-1:0] rgb_t;

	// Backlight duty ratio
	typedef logic [cDutyWidth-1:0] duty_t;

endpackage

//--- logic/videoTimingIf.sv
//----------------------------------------------------------
// Raster timing bundle from the sync generator
// Driven through source, read by the output stage via sink
//----------------------------------------------------------
`timescale 1ns/1ps

interface videoTimingIf;

	// Levels from the sync generator, all registered
	logic hSync;
	logic vSync;
	logic de;
	// One cycle at the last active pixel
	logic frameEnd;

	modport source (
		output hSync, vSync, de, frameEnd
	);

	// Output stage only needs the levels
	modport sink (
		input hSync, vSync, de
	);

endinterface

//--- logic/videoSyncGen.sv
//----------------------------------------------------------
// Horizontal and vertical raster counters with sync, DE
// and end-of-frame, all registered from the counter values
//----------------------------------------------------------
`timescale 1ns/1ps

module videoSyncGen (
	input  logic            iVideoClk,
	input  logic            rstN,
	input  videoPkg::hPos_t hDisplay,
	input  videoPkg::vPos_t vDisplay,
	input  videoPkg::hPos_t hSyncStart,
	input  videoPkg::hPos_t hSyncEnd,
	input  videoPkg::hPos_t hSyncMax,
	input  videoPkg::vPos_t vSyncStart,
	input  videoPkg::vPos_t vSyncEnd,
	input  videoPkg::vPos_t vSyncMax,
	videoTimingIf.source    timing
);
	import videoPkg::*;

	hPos_t hCount;
	vPos_t vCount;
	logic  hLast;
	logic  vLast;

	// Last count of each period
	assign hLast = (hCount == hPos_t'(hSyncMax - 1'b1));
	assign vLast = (vCount == vPos_t'(vSyncMax - 1'b1));

	//------------------------------------------------------------
	// Raster counters
	//------------------------------------------------------------
	// Vertical starts in blanking so the FIFO can fill first
	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			hCount <= '0;
			vCount <= vDisplay;
		end
		else if (hLast)
		begin
			hCount <= '0;
			// Line done, step or wrap the frame
			if (vLast)
				vCount <= '0;
			else
				vCount <= vCount + 1'b1;
		end
		else
			hCount <= hCount + 1'b1;
	end

	//------------------------------------------------------------
	// Registered timing outputs
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			timing.hSync    <= 1'b0;
			timing.vSync    <= 1'b0;
			timing.de       <= 1'b0;
			timing.frameEnd <= 1'b0;
		end
		else
		begin
			timing.hSync    <= (hCount >= hSyncStart) && (hCount < hSyncEnd);
			timing.vSync    <= (vCount >= vSyncStart) && (vCount < vSyncEnd);
			timing.de       <= (hCount < hDisplay) && (vCount < vDisplay);
			// Last active pixel of the frame
			timing.frameEnd <= (hCount == hPos_t'(hDisplay - 1'b1))
				&& (vCount == vPos_t'(vDisplay - 1'b1));
		end
	end

endmodule

//--- logic/videoPixelGen.sv
//----------------------------------------------------------
// Test pattern source writing pixels in raster order
// Writes whenever the pixel FIFO has room
//----------------------------------------------------------
`timescale 1ns/1ps

module videoPixelGen (
	input  logic            iVideoClk,
	input  logic            rstN,
	input  videoPkg::hPos_t hDisplay,
	input  videoPkg::vPos_t vDisplay,
	input  logic            full,
	output videoPkg::rgb_t  wrData,
	output logic            wrEn
);
	import videoPkg::*;

	hPos_t x;
	vPos_t y;

	// Every strobe is accepted, no write against a full FIFO
	assign wrEn = !full;

	// R = x mod 16, G = y mod 16, B = low bits of x + y
	assign wrData = {x[cColorWidth-1:0], y[cColorWidth-1:0],
		x[cColorWidth-1:0] + y[cColorWidth-1:0]};

	// Position steps only on an accepted write
	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			x <= '0;
			y <= '0;
		end
		else if (wrEn)
		begin
			if (x == hPos_t'(hDisplay - 1'b1))
			begin
				x <= '0;
				// Wrap to the top after the last line
				if (y == vPos_t'(vDisplay - 1'b1))
					y <= '0;
				else
					y <= y + 1'b1;
			end
			else
				x <= x + 1'b1;
		end
	end

endmodule

//--- logic/pixelFifo.sv
//----------------------------------------------------------
// Single-clock pixel FIFO with registered read data
// Read in cycle n shows on rdData in cycle n+1
//----------------------------------------------------------
`timescale 1ns/1ps

module pixelFifo #(
	parameter int pFifoDepth = 16
) (
	input  logic           iVideoClk,
	input  logic           rstN,
	input  videoPkg::rgb_t wrData,
	input  logic           wrEn,
	input  logic           rdEn,
	output videoPkg::rgb_t rdData,
	output logic           full,
	output logic           empty
);
	import videoPkg::*;

	localparam int cAddrWidth = $clog2(pFifoDepth);

	rgb_t                mem [pFifoDepth];
	logic [cAddrWidth:0] wrPtr;
	logic [cAddrWidth:0] rdPtr;

	// Extra pointer bit tells full from empty
	assign empty = (wrPtr == rdPtr);
	assign full  = (wrPtr[cAddrWidth] != rdPtr[cAddrWidth])
		&& (wrPtr[cAddrWidth-1:0] == rdPtr[cAddrWidth-1:0]);

	//------------------------------------------------------------
	// Pointers
	//------------------------------------------------------------
	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			wrPtr <= '0;
			rdPtr <= '0;
		end
		else
		begin
			if (wrEn && !full)
				wrPtr <= wrPtr + 1'b1;
			// A read on empty is dropped
			if (rdEn && !empty)
				rdPtr <= rdPtr + 1'b1;
		end
	end

	// Storage and read register
	always_ff @(posedge iVideoClk)
	begin
		if (wrEn && !full)
			mem[wrPtr[cAddrWidth-1:0]] <= wrData;
		if (rdEn && !empty)
			rdData <= mem[rdPtr[cAddrWidth-1:0]];
	end

endmodule

//--- logic/tftOutputStage.sv
//----------------------------------------------------------
// Pin stage aligning sync and DE with the FIFO latency
// Also flags a DE cycle that found the FIFO empty
//----------------------------------------------------------
`timescale 1ns/1ps

module tftOutputStage (
	input  logic                              iVideoClk,
	input  logic                              rstN,
	videoTimingIf.sink                        timing,
	input  videoPkg::rgb_t                    rdData,
	input  logic                              empty,
	output logic [videoPkg::cColorWidth-1:0]  tftR,
	output logic [videoPkg::cColorWidth-1:0]  tftG,
	output logic [videoPkg::cColorWidth-1:0]  tftB,
	output logic                              tftHSync,
	output logic                              tftVSync,
	output logic                              tftDe,
	output logic                              underflow
);
	import videoPkg::*;

	logic [1:0] hSyncPipe;
	logic [1:0] vSyncPipe;
	logic [1:0] dePipe;
	// rdData holds a real pixel this cycle
	logic       rdValid;
	rgb_t       colorQ;

	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			hSyncPipe <= '0;
			vSyncPipe <= '0;
			dePipe    <= '0;
			rdValid   <= 1'b0;
			colorQ    <= '0;
			underflow <= 1'b0;
		end
		else
		begin
			// Two cycles, matches FIFO read plus color register
			hSyncPipe <= {hSyncPipe[0], timing.hSync};
			vSyncPipe <= {vSyncPipe[0], timing.vSync};
			dePipe    <= {dePipe[0], timing.de};
			rdValid   <= timing.de && !empty;
			// Blank outside DE and on a starved read
			colorQ    <= rdValid ? rdData : '0;
			// Sticky until reset
			if (timing.de && empty)
				underflow <= 1'b1;
		end
	end

	assign tftHSync = hSyncPipe[1];
	assign tftVSync = vSyncPipe[1];
	assign tftDe    = dePipe[1];
	assign tftR     = colorQ[2*cColorWidth +: cColorWidth];
	assign tftG     = colorQ[cColorWidth +: cColorWidth];
	assign tftB     = colorQ[0 +: cColorWidth];

endmodule

//--- logic/backlightPwm.sv
//----------------------------------------------------------
// Backlight dimming, 256-cycle PWM period
// High for blDuty cycles of each period
//----------------------------------------------------------
`timescale 1ns/1ps

module backlightPwm (
	input  logic           iVideoClk,
	input  logic           rstN,
	input  videoPkg::duty_t blDuty,
	output logic           tftBackLight
);
	import videoPkg::*;

	duty_t pwmCount;

	// Free-running counter, wraps every 256 cycles
	always_ff @(posedge iVideoClk)
	begin
		if (!rstN)
		begin
			pwmCount     <= '0;
			tftBackLight <= 1'b0;
		end
		else
		begin
			pwmCount     <= pwmCount + 1'b1;
			tftBackLight <= (pwmCount < blDuty);
		end
	end

endmodule

//--- logic/videoTxUnit.sv
//----------------------------------------------------------
// TFT video transmit top level on a single video clock
// Pattern source, FIFO, timing, pin stage and backlight
//----------------------------------------------------------
`timescale 1ns/1ps

module videoTxUnit #(
	parameter int pFifoDepth = 16
) (
	input  logic                             iVideoClk,
	input  logic                             rstN,
	input  videoPkg::hPos_t                  hDisplay,
	input  videoPkg::vPos_t                  vDisplay,
	input  videoPkg::hPos_t                  hSyncStart,
	input  videoPkg::hPos_t                  hSyncEnd,
	input  videoPkg::hPos_t                  hSyncMax,
	input  videoPkg::vPos_t                  vSyncStart,
	input  videoPkg::vPos_t                  vSyncEnd,
	input  videoPkg::vPos_t                  vSyncMax,
	input  videoPkg::duty_t                  blDuty,
	output logic [videoPkg::cColorWidth-1:0] tftR,
	output logic [videoPkg::cColorWidth-1:0] tftG,
	output logic [videoPkg::cColorWidth-1:0] tftB,
	output logic                             tftHSync,
	output logic                             tftVSync,
	output logic                             tftDe,
	output logic                             tftBackLight,
	output logic                             frameEnd,
	output logic                             underflow
);
	import videoPkg::*;

	// Writer side of the pixel FIFO
	rgb_t wrData;
	logic wrEn;
	logic full;
	// Reader side
	rgb_t rdData;
	logic empty;

	videoTimingIf videoTiming ();

	//------------------------------------------------------------
	// Timing and pixel path
	//------------------------------------------------------------
	videoSyncGen u_syncGen (
		.iVideoClk (iVideoClk), .rstN (rstN),
		.hDisplay (hDisplay), .vDisplay (vDisplay),
		.hSyncStart (hSyncStart), .hSyncEnd (hSyncEnd), .hSyncMax (hSyncMax),
		.vSyncStart (vSyncStart), .vSyncEnd (vSyncEnd), .vSyncMax (vSyncMax),
		.timing (videoTiming)
	);

	videoPixelGen u_pixelGen (
		.iVideoClk (iVideoClk), .rstN (rstN),
		.hDisplay (hDisplay), .vDisplay (vDisplay),
		.full (full), .wrData (wrData), .wrEn (wrEn)
	);

	// DE is the read strobe
	pixelFifo #(.pFifoDepth (pFifoDepth)) u_pixelFifo (
		.iVideoClk (iVideoClk), .rstN (rstN),
		.wrData (wrData), .wrEn (wrEn), .rdEn (videoTiming.de),
		.rdData (rdData), .full (full), .empty (empty)
	);

	tftOutputStage u_outputStage (
		.iVideoClk (iVideoClk), .rstN (rstN), .timing (videoTiming),
		.rdData (rdData), .empty (empty),
		.tftR (tftR), .tftG (tftG), .tftB (tftB),
		.tftHSync (tftHSync), .tftVSync (tftVSync), .tftDe (tftDe),
		.underflow (underflow)
	);

	backlightPwm u_backlightPwm (
		.iVideoClk (iVideoClk), .rstN (rstN),
		.blDuty (blDuty), .tftBackLight (tftBackLight)
	);

	// Undelayed end-of-frame pulse
	assign frameEnd = videoTiming.frameEnd;

endmodule

//--- test/videoTxUnit_properties.sv
//----------------------------------------------------------
// Concurrent assertions on the transmit unit
// Attached to every videoTxUnit instance by bind
//----------------------------------------------------------
`timescale 1ns/1ps

module videoTxUnitProperties (
	input logic iVideoClk,
	input logic rstN,
	input logic de,
	input logic tftDe,
	input logic tftHSync,
	input logic tftVSync,
	input logic tftBackLight,
	input logic frameEnd,
	input logic underflow
);

	// Pin DE is the internal DE two edges later
	deTwoCycleDelay: assert property (
		@(posedge iVideoClk) disable iff (!rstN)
		$past(rstN, 2) |-> (tftDe == $past(de, 2))
	) else $error("tftDe is not the internal DE delayed by two cycles");

	// Last pin pixel of the frame ends two edges after frameEnd
	frameEndAtLastPixel: assert property (
		@(posedge iVideoClk) disable iff (!rstN)
		$past(frameEnd, 3) |-> ($past(tftDe) && !tftDe)
	) else $error("frameEnd does not mark the last DE cycle of the frame");

	// FIFO never starves during DE
	noUnderflow: assert property (
		@(posedge iVideoClk) disable iff (!rstN) !underflow
	) else $error("pixel FIFO ran empty during DE");

	// A reset edge clears every output
	lowAfterReset: assert property (
		@(posedge iVideoClk) !rstN |=>
		!(tftHSync || tftVSync || tftDe || tftBackLight || frameEnd || underflow)
	) else $error("outputs not low after a reset edge");

endmodule

bind videoTxUnit videoTxUnitProperties u_properties (
	.iVideoClk (iVideoClk), .rstN (rstN), .de (videoTiming.de), .tftDe (tftDe),
	.tftHSync (tftHSync), .tftVSync (tftVSync),
	.tftBackLight (tftBackLight), .frameEnd (frameEnd), .underflow (underflow)
);

//--- test/videoChecker.sv
//----------------------------------------------------------
// Watches the TFT pins and compares them with the expected
// raster, pattern and backlight, one result line per test
//----------------------------------------------------------
`timescale 1ns/1ps

module videoChecker (
	input  logic                             iVideoClk,
	input  logic                             rstN,
	input  videoPkg::hPos_t                  hDisplay,
	input  videoPkg::vPos_t                  vDisplay,
	input  videoPkg::hPos_t                  hSyncStart,
	input  videoPkg::hPos_t                  hSyncEnd,
	input  videoPkg::hPos_t                  hSyncMax,
	input  videoPkg::vPos_t                  vSyncStart,
	input  videoPkg::vPos_t                  vSyncEnd,
	input  videoPkg::duty_t                  blDuty,
	input  logic [videoPkg::cColorWidth-1:0] tftR,
	input  logic [videoPkg::cColorWidth-1:0] tftG,
	input  logic [videoPkg::cColorWidth-1:0] tftB,
	input  logic                             tftHSync,
	input  logic                             tftVSync,
	input  logic                             tftDe,
	input  logic                             tftBackLight,
	input  logic                             frameEnd,
	input  logic                             underflow,
	input  logic                             pwmReq,
	output logic                             pwmDone,
	output logic                             videoDone,
	output int                               testCount,
	output int                               failCount
);
	import videoPkg::*;

	// Error tallies of the video tests
	int   pixErr = 0, hErr = 0, vErr = 0, feErr = 0, ufErr = 0;
	int   videoTests = 0, videoFailed = 0;
	int   blTests = 0, blFailed = 0, highCount;
	// Raster tracking, cycle is the sample index
	int   cycle = 0, resetSeen = 0, framesDone = 0;
	int   pixIdx = 0, pixX, pixY, deRun = 0, deRuns = 0;
	int   feSeen = 0, feCycle = -10, hRise = -1, hHigh = 0, vHigh = 0;
	logic started = 1'b0, ufSeen = 1'b0;
	logic hSyncQ = 1'b0, vSyncQ = 1'b0, deQ = 1'b0;
	rgb_t pinColor;

	assign testCount = videoTests + blTests;
	assign failCount = videoFailed + blFailed;

	// Expected pattern: R = x, G = y, B = x + y, all mod 16
	function automatic rgb_t expectedPixel(input int x, input int y);
		logic [3:0] r, g, b;
		r = 4'(x % 16);
		g = 4'(y % 16);
		b = 4'((x + y) % 16);
		return {r, g, b};
	endfunction

	// Backlight is high for duty cycles of every 256
	function automatic int expectedHighCycles(input duty_t duty);
		return int'(duty);
	endfunction

	task automatic reportError(input string msg);
		$display("[FAIL] %0t ns: %s", $time, msg);
	endtask

	// Prints the result line, returns 1 on failure
	function automatic int testFailed(input string name, input int errs);
		if (errs == 0)
			$display("Test %s: passed", name);
		else
			$display("Test %s: %0d errors", name, errs);
		return (errs == 0) ? 0 : 1;
	endfunction

	//------------------------------------------------------------
	// Video pins, sampled at the rising edge
	//------------------------------------------------------------
	always @(posedge iVideoClk)
	begin
		pinColor = {tftR, tftG, tftB};
		cycle    = cycle + 1;
		if (!rstN)
		begin
			// First edge in reset clears the outputs
			if (resetSeen > 0 && (tftHSync || tftVSync || tftDe || tftBackLight
				|| frameEnd || underflow || pinColor != '0))
			begin
				reportError("outputs not low during reset");
				ufErr++;
			end
			resetSeen++;
			videoDone <= 1'b0;
		end
		else if (!videoDone)
		begin
			if (underflow && !ufSeen)
			begin
				reportError("underflow flag set");
				ufErr++;
				ufSeen = 1'b1;
			end
			// Horizontal sync width and period
			if (tftHSync)
				hHigh++;
			if (tftHSync && !hSyncQ)
			begin
				if (hRise >= 0 && cycle - hRise != int'(hSyncMax))
				begin
					reportError($sformatf("hsync period %0d, expected %0d",
						cycle - hRise, hSyncMax));
					hErr++;
				end
				hRise = cycle;
			end
			if (!tftHSync && hSyncQ)
			begin
				if (hHigh != int'(hSyncEnd - hSyncStart))
				begin
					reportError($sformatf("hsync width %0d cycles", hHigh));
					hErr++;
				end
				hHigh = 0;
			end
			// Vertical sync width in lines
			if (tftVSync)
				vHigh++;
			if (!tftVSync && vSyncQ)
			begin
				if (vHigh != int'(vSyncEnd - vSyncStart) * int'(hSyncMax))
				begin
					reportError($sformatf("vsync width %0d cycles", vHigh));
					vErr++;
				end
				vHigh = 0;
			end
			// vsync rise closes a frame
			if (tftVSync && !vSyncQ)
			begin
				if (started)
				begin
					if (pixIdx != int'(hDisplay) * int'(vDisplay))
					begin
						reportError($sformatf("%0d pixels in the frame", pixIdx));
						pixErr++;
					end
					if (deRuns != int'(vDisplay))
					begin
						reportError($sformatf("%0d DE runs in the frame", deRuns));
						vErr++;
					end
					if (feSeen != 1)
					begin
						reportError($sformatf("%0d frameEnd pulses in the frame", feSeen));
						feErr++;
					end
					framesDone++;
					if (framesDone == 3)
					begin
						videoFailed += testFailed("pixels", pixErr);
						videoFailed += testFailed("horizontal timing", hErr);
						videoFailed += testFailed("vertical timing", vErr);
						videoFailed += testFailed("frame end", feErr);
						videoFailed += testFailed("underflow and reset", ufErr);
						videoTests = 5;
						videoDone <= 1'b1;
					end
				end
				started = 1'b1;
				pixIdx  = 0;
				deRuns  = 0;
				feSeen  = 0;
			end
			//------------------------------------------------------------
			// Pixels in raster order
			//------------------------------------------------------------
			if (tftDe)
			begin
				if (!started)
				begin
					reportError("pixel shown before the first frame");
					pixErr++;
				end
				else
				begin
					pixX = pixIdx % int'(hDisplay);
					pixY = pixIdx / int'(hDisplay);
					if (pinColor !== expectedPixel(pixX, pixY))
					begin
						reportError($sformatf("pixel (%0d,%0d) is %h, expected %h",
							pixX, pixY, pinColor, expectedPixel(pixX, pixY)));
						pixErr++;
					end
					// Last pixel two edges after frameEnd
					if (pixIdx == int'(hDisplay) * int'(vDisplay) - 1
						&& cycle != feCycle + 2)
					begin
						reportError("last pixel not two cycles after frameEnd");
						feErr++;
					end
				end
				pixIdx++;
				deRun++;
			end
			else
			begin
				if (pinColor != '0)
				begin
					reportError($sformatf("color %h while DE is low", pinColor));
					pixErr++;
				end
				if (deQ)
				begin
					if (deRun != int'(hDisplay))
					begin
						reportError($sformatf("DE run of %0d cycles", deRun));
						vErr++;
					end
					deRuns++;
					deRun = 0;
				end
			end
			if (frameEnd)
			begin
				feSeen++;
				feCycle = cycle;
			end
			hSyncQ = tftHSync;
			vSyncQ = tftVSync;
			deQ    = tftDe;
		end
	end

	//------------------------------------------------------------
	// Backlight, one full period to settle then a 256 window
	//------------------------------------------------------------
	initial
	begin
		pwmDone <= 1'b0;
		forever
		begin
			@(posedge iVideoClk);
			if (pwmReq && !pwmDone)
			begin
				repeat (256)
					@(posedge iVideoClk);
				highCount = 0;
				repeat (256)
				begin
					@(posedge iVideoClk);
					if (tftBackLight)
						highCount++;
				end
				blTests++;
				if (highCount != expectedHighCycles(blDuty))
				begin
					reportError($sformatf("backlight high %0d cycles, expected %0d",
						highCount, expectedHighCycles(blDuty)));
					blFailed++;
					$display("Test backlight duty %0d: 1 errors", blDuty);
				end
				else
					$display("Test backlight duty %0d: passed", blDuty);
				pwmDone <= 1'b1;
			end
			else if (!pwmReq)
				pwmDone <= 1'b0;
		end
	end

endmodule

//--- test/videoTxUnitTb.sv
//----------------------------------------------------------
// Testbench top for the TFT video transmit unit
// Drives raster timing, reset and backlight duty inputs
//----------------------------------------------------------
`timescale 1ns/1ps

module videoTxUnitTb;
	import videoPkg::*;

	// Small display raster
	localparam int cHDisplay   = 16;
	localparam int cHSyncStart = 18;
	localparam int cHSyncEnd   = 20;
	localparam int cHSyncMax   = 24;
	localparam int cVDisplay   = 4;
	localparam int cVSyncStart = 5;
	localparam int cVSyncEnd   = 6;
	localparam int cVSyncMax   = 7;

	localparam int cResetCycles = 16;
	localparam int cFrameCycles = cHSyncMax * cVSyncMax;
	// Request, settle period and counting window per duty
	localparam int cDutyCycles  = 3 * 256;
	localparam int cDutyTests   = 5;
	// Five video tests plus one per duty
	localparam int cTestTotal   = 5 + cDutyTests;
	// Blank lead-in plus three frames, then the duty tests, plus slack
	localparam int cWatchdogCycles = cResetCycles + 4 * cFrameCycles
		+ cDutyTests * cDutyCycles + 600;

	logic                   iVideoClk = 1'b0;
	logic                   rstN;
	hPos_t                  hDisplay, hSyncStart, hSyncEnd, hSyncMax;
	vPos_t                  vDisplay, vSyncStart, vSyncEnd, vSyncMax;
	duty_t                  blDuty;
	logic [cColorWidth-1:0] tftR, tftG, tftB;
	logic                   tftHSync, tftVSync, tftDe;
	logic                   tftBackLight, frameEnd, underflow;
	// Checker handshake and results
	logic                   pwmReq;
	logic                   pwmDone;
	logic                   videoDone;
	int                     testCount;
	int                     failCount;
	logic [31:0]            rngState;

	always #50 iVideoClk = ~iVideoClk;

	videoTxUnit #(.pFifoDepth (16)) u_videoTxUnit (
		.iVideoClk (iVideoClk), .rstN (rstN),
		.hDisplay (hDisplay), .vDisplay (vDisplay),
		.hSyncStart (hSyncStart), .hSyncEnd (hSyncEnd), .hSyncMax (hSyncMax),
		.vSyncStart (vSyncStart), .vSyncEnd (vSyncEnd), .vSyncMax (vSyncMax),
		.blDuty (blDuty), .tftR (tftR), .tftG (tftG), .tftB (tftB),
		.tftHSync (tftHSync), .tftVSync (tftVSync), .tftDe (tftDe),
		.tftBackLight (tftBackLight), .frameEnd (frameEnd), .underflow (underflow)
	);

	videoChecker u_checker (
		.iVideoClk (iVideoClk), .rstN (rstN),
		.hDisplay (hDisplay), .vDisplay (vDisplay),
		.hSyncStart (hSyncStart), .hSyncEnd (hSyncEnd), .hSyncMax (hSyncMax),
		.vSyncStart (vSyncStart), .vSyncEnd (vSyncEnd), .blDuty (blDuty),
		.tftR (tftR), .tftG (tftG), .tftB (tftB),
		.tftHSync (tftHSync), .tftVSync (tftVSync), .tftDe (tftDe),
		.tftBackLight (tftBackLight), .frameEnd (frameEnd), .underflow (underflow),
		.pwmReq (pwmReq), .pwmDone (pwmDone), .videoDone (videoDone),
		.testCount (testCount), .failCount (failCount)
	);

	// 32-bit xorshift step
	function automatic logic [31:0] xorshift32(input logic [31:0] state);
		logic [31:0] v;
		v = state;
		v = v ^ (v << 13);
		v = v ^ (v >> 17);
		v = v ^ (v << 5);
		return v;
	endfunction

	// Set a duty, let the checker measure it, then release
	task automatic measureDuty(input duty_t duty);
		@(posedge iVideoClk);
		#5;
		blDuty = duty;
		pwmReq = 1'b1;
		while (!pwmDone)
			@(posedge iVideoClk);
		#5;
		pwmReq = 1'b0;
		while (pwmDone)
			@(posedge iVideoClk);
	endtask

	//------------------------------------------------------------
	// Stimulus
	//------------------------------------------------------------
	initial
	begin
		rstN       = 1'b0;
		hDisplay   = hPos_t'(cHDisplay);
		hSyncStart = hPos_t'(cHSyncStart);
		hSyncEnd   = hPos_t'(cHSyncEnd);
		hSyncMax   = hPos_t'(cHSyncMax);
		vDisplay   = vPos_t'(cVDisplay);
		vSyncStart = vPos_t'(cVSyncStart);
		vSyncEnd   = vPos_t'(cVSyncEnd);
		vSyncMax   = vPos_t'(cVSyncMax);
		blDuty     = '0;
		pwmReq     = 1'b0;
		rngState   = 32'd1473;
		repeat (cResetCycles)
			@(posedge iVideoClk);
		#5;
		rstN = 1'b1;
		// Video tests run by themselves, checker flags the end
		while (!videoDone)
			@(posedge iVideoClk);
		for (int i = 0; i < 3; i++)
		begin
			rngState = xorshift32(rngState);
			measureDuty(rngState[7:0]);
		end
		// Both ends of the duty range
		measureDuty(8'd0);
		measureDuty(8'd255);
		$display("Summary: %0d of %0d tests run, %0d failed", testCount, cTestTotal, failCount);
		if (failCount == 0 && testCount == cTestTotal)
			$display("Everything OK");
		else
			$display("Something failed");
		$finish;
	end

	// Watchdog
	initial
	begin
		repeat (cWatchdogCycles)
			@(posedge iVideoClk);
		$display("Timeout: the tests did not complete within %0d clock cycles", cWatchdogCycles);
		$display("Something failed");
		$finish;
	end

endmodule

//--- videoTxUnit.f
logic/videoPkg.sv
logic/videoTimingIf.sv
logic/videoSyncGen.sv
logic/videoPixelGen.sv
logic/pixelFifo.sv
logic/tftOutputStage.sv
logic/backlightPwm.sv
logic/videoTxUnit.sv
test/videoTxUnit_properties.sv
test/videoChecker.sv
test/videoTxUnitTb.sv

//--- Makefile
# Verilator flow for the TFT video transmit unit
TOP := videoTxUnitTb
LOG := sim.log

.PHONY: lint sim clean

lint:
	verilator --lint-only -Wall --timing --top-module $(TOP) -f videoTxUnit.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) \
		-f videoTxUnit.f -Mdir obj_dir
	./obj_dir/V$(TOP) | tee $(LOG)
	grep -q "Everything OK" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
